// ==== Bender.yml ====
package:
  name: qoi_encoder

export_include_dirs:
  - design

sources:
  - design/qoiPkg.sv
  - design/qoiDeltaStage.sv
  - design/qoiOpSelect.sv
  - design/qoiByteEmitter.sv
  - design/qoiEncoderTop.sv
  - target: test
    files:
      - tb/qoiEncoderTb.sv

// ==== design/qoiByteEmitter.sv ====
// ####################
// QOI byte emitter
// Shifts byte groups and the end marker out
// over four-phase req/ack
// ####################
`timescale 1ns/1ns
`include "qoiEncoder_macros.svh"

module qoiByteEmitter (
	input logic clk,
	input logic reset,
	input logic groupValid,
	output logic groupReady,
	input logic [`QOI_GROUP_BYTES*8-1:0] groupBytes,
	input logic [3:0] groupLen,
	input logic groupLast,
	output logic byteReq,
	output logic [7:0] byteData,
	output logic byteLast,
	input logic byteAck
);

	logic [`QOI_GROUP_BYTES*8-1:0] shiftReg;
	logic [3:0] bytesLeft;
	logic [3:0] footerLeft;
	logic waitDrop;
	logic busy;
	logic loadGroup;
	logic byteDone;

	assign busy = (bytesLeft != 4'd0) || (footerLeft != 4'd0);
	assign groupReady = !busy;
	assign loadGroup = groupValid && groupReady;
	assign byteDone = byteReq && byteAck;

	// Group bytes first, then the end marker
	always_comb begin
		if (bytesLeft != 4'd0) begin
			byteData = shiftReg[`QOI_GROUP_BYTES*8-1 -: 8];
		end else if (footerLeft == 4'd1) begin
			byteData = 8'h01;
		end else begin
			byteData = 8'h00;
		end
	end

	assign byteLast = (bytesLeft == 4'd0) && (footerLeft == 4'd1);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			byteReq <= 1'b0;
			waitDrop <= 1'b0;
			bytesLeft <= 4'd0;
			footerLeft <= 4'd0;
		end else begin
			if (loadGroup) begin
				// Empty groups only load a footer, if any
				bytesLeft <= groupLen;
				footerLeft <= groupLast ? 4'(`QOI_FOOTER_LEN) : 4'd0;
			end

			if (!byteReq && !waitDrop && busy) begin
				byteReq <= 1'b1;
			end else if (byteDone) begin
				byteReq <= 1'b0;
				waitDrop <= 1'b1;
				if (bytesLeft != 4'd0) begin
					bytesLeft <= bytesLeft - 4'd1;
				end else begin
					footerLeft <= footerLeft - 4'd1;
				end
			end else if (waitDrop && !byteAck) begin
				// Sink has returned to zero
				waitDrop <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (loadGroup) begin
			shiftReg <= groupBytes;
		end else if (byteDone && bytesLeft != 4'd0) begin
			shiftReg <= {shiftReg[`QOI_GROUP_BYTES*8-9:0], 8'h00};
		end
	end

	// Output byte holds for the whole request phase
	assert property (@(posedge clk) disable iff (reset)
		byteReq && $past(byteReq) |-> $stable(byteData) && $stable(byteLast));

endmodule

// ==== design/qoiDeltaStage.sv ====
// ####################
// QOI delta stage
// Takes pixels over four-phase req/ack, registers the
// channel differences and the hash index
// ####################
`timescale 1ns/1ns
`include "qoiEncoder_macros.svh"

module qoiDeltaStage (
	input logic clk,
	input logic reset,
	input logic pixelReq,
	input logic [31:0] pixelData,
	input logic pixelLast,
	output logic pixelAck,
	output logic deltaValid,
	input logic deltaReady,
	output qoiPkg::qoiPixel_u curPixel,
	output qoiPkg::qoiPixel_u prevPixel,
	output logic signed [8:0] diffR,
	output logic signed [8:0] diffG,
	output logic signed [8:0] diffB,
	output logic [`QOI_INDEX_WIDTH-1:0] hashIndex,
	output logic isLast
);

	qoiPkg::qoiPixel_u inPixel;
	qoiPkg::qoiPixel_u lastPixel;
	logic stageFree;
	logic take;
	logic signed [8:0] diffRNext;
	logic signed [8:0] diffGNext;
	logic signed [8:0] diffBNext;
	logic [`QOI_INDEX_WIDTH-1:0] hashNext;

	assign inPixel.word = pixelData;

	// Register is free when empty or being drained this cycle
	assign stageFree = !deltaValid || deltaReady;
	assign take = pixelReq && !pixelAck && stageFree;

	// Differences wrap in 9 bits, current minus previous
	assign diffRNext = {1'b0, inPixel.ch.r} - {1'b0, lastPixel.ch.r};
	assign diffGNext = {1'b0, inPixel.ch.g} - {1'b0, lastPixel.ch.g};
	assign diffBNext = {1'b0, inPixel.ch.b} - {1'b0, lastPixel.ch.b};

	// r*3 + g*5 + b*7 + a*11, modulo the table size
	assign hashNext = `QOI_INDEX_WIDTH'(inPixel.ch.r * 3 + inPixel.ch.g * 5
		+ inPixel.ch.b * 7 + inPixel.ch.a * 11);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			pixelAck <= 1'b0;
			deltaValid <= 1'b0;
			lastPixel.word <= 32'h000000FF;
		end else begin
			if (take) begin
				pixelAck <= 1'b1;
				lastPixel <= inPixel;
			end else if (!pixelReq) begin
				// Return to zero once the source lets go
				pixelAck <= 1'b0;
			end

			if (take) begin
				deltaValid <= 1'b1;
			end else if (deltaReady) begin
				deltaValid <= 1'b0;
			end
		end
	end

	// Stage payload
	always_ff @(posedge clk) begin
		if (take) begin
			curPixel <= inPixel;
			prevPixel <= lastPixel;
			diffR <= diffRNext;
			diffG <= diffGNext;
			diffB <= diffBNext;
			hashIndex <= hashNext;
			isLast <= pixelLast;
		end
	end

	// Ack only answers a request seen on the capture edge
	assert property (@(posedge clk) disable iff (reset)
		$rose(pixelAck) |-> $past(pixelReq));

endmodule

// ==== design/qoiEncoderTop.sv ====
// ####################
// QOI encoder top
// Delta stage, op select and byte emitter in a row
// ####################
`timescale 1ns/1ns
`include "qoiEncoder_macros.svh"

module qoiEncoderTop (
	input logic clk,
	input logic reset,
	input logic pixelReq,
	input logic [31:0] pixelData,
	input logic pixelLast,
	output logic pixelAck,
	output logic byteReq,
	output logic [7:0] byteData,
	output logic byteLast,
	input logic byteAck
);

	// Delta to op select
	logic deltaValid;
	logic deltaReady;
	qoiPkg::qoiPixel_u curPixel;
	qoiPkg::qoiPixel_u prevPixel;
	logic signed [8:0] diffR;
	logic signed [8:0] diffG;
	logic signed [8:0] diffB;
	logic [`QOI_INDEX_WIDTH-1:0] hashIndex;
	logic isLast;

	// Op select to emitter
	logic groupValid;
	logic groupReady;
	logic [`QOI_GROUP_BYTES*8-1:0] groupBytes;
	logic [3:0] groupLen;
	logic groupLast;

	qoiDeltaStage deltaStage (
		.clk(clk),
		.reset(reset),
		.pixelReq(pixelReq),
		.pixelData(pixelData),
		.pixelLast(pixelLast),
		.pixelAck(pixelAck),
		.deltaValid(deltaValid),
		.deltaReady(deltaReady),
		.curPixel(curPixel),
		.prevPixel(prevPixel),
		.diffR(diffR),
		.diffG(diffG),
		.diffB(diffB),
		.hashIndex(hashIndex),
		.isLast(isLast)
	);

	qoiOpSelect opSelect (
		.clk(clk),
		.reset(reset),
		.deltaValid(deltaValid),
		.deltaReady(deltaReady),
		.curPixel(curPixel),
		.prevPixel(prevPixel),
		.diffR(diffR),
		.diffG(diffG),
		.diffB(diffB),
		.hashIndex(hashIndex),
		.isLast(isLast),
		.groupValid(groupValid),
		.groupReady(groupReady),
		.groupBytes(groupBytes),
		.groupLen(groupLen),
		.groupLast(groupLast)
	);

	qoiByteEmitter byteEmitter (
		.clk(clk),
		.reset(reset),
		.groupValid(groupValid),
		.groupReady(groupReady),
		.groupBytes(groupBytes),
		.groupLen(groupLen),
		.groupLast(groupLast),
		.byteReq(byteReq),
		.byteData(byteData),
		.byteLast(byteLast),
		.byteAck(byteAck)
	);

endmodule

// ==== design/qoiEncoder_macros.svh ====
// ####################
// QOI encoder constants
// Sizes, limits and chunk tags
// ####################
`ifndef QOI_ENCODER_MACROS_SVH
`define QOI_ENCODER_MACROS_SVH

// Pixel geometry and hash table
`define QOI_CHANNEL_WIDTH 8
`define QOI_INDEX_SIZE 64
`define QOI_INDEX_WIDTH 6

// Encoder limits
`define QOI_RUN_MAX 62
`define QOI_GROUP_BYTES 6
`define QOI_FOOTER_LEN 8

// Two-bit chunk tags
`define QOI_TAG_INDEX 2'd0
`define QOI_TAG_DIFF 2'd1
`define QOI_TAG_LUMA 2'd2
`define QOI_TAG_RUN 2'd3

// Full-byte chunk tags
`define QOI_OP_RGB 8'hFE
`define QOI_OP_RGBA 8'hFF

`endif

// ==== design/qoiOpSelect.sv ====
// ####################
// QOI op select
// Index table, run counter and chunk choice,
// one byte group per pixel
// ####################
`timescale 1ns/1ns
`include "qoiEncoder_macros.svh"

module qoiOpSelect (
	input logic clk,
	input logic reset,
	input logic deltaValid,
	output logic deltaReady,
	input qoiPkg::qoiPixel_u curPixel,
	input qoiPkg::qoiPixel_u prevPixel,
	input logic signed [8:0] diffR,
	input logic signed [8:0] diffG,
	input logic signed [8:0] diffB,
	input logic [`QOI_INDEX_WIDTH-1:0] hashIndex,
	input logic isLast,
	output logic groupValid,
	input logic groupReady,
	output logic [`QOI_GROUP_BYTES*8-1:0] groupBytes,
	output logic [3:0] groupLen,
	output logic groupLast
);

	qoiPkg::qoiPixel_u indexTable [`QOI_INDEX_SIZE];
	qoiPkg::qoiPixel_u tableEntry;
	logic [`QOI_INDEX_SIZE-1:0] entryValid;
	logic [5:0] runCount;
	logic [5:0] runNext;
	logic [5:0] runCountNext;
	logic consume;
	logic samePixel;
	logic indexHit;
	logic alphaSame;
	logic diffFit;
	logic lumaFit;
	logic tableWrite;
	logic signed [9:0] diffRG;
	logic signed [9:0] diffBG;
	logic signed [8:0] diffRBias;
	logic signed [8:0] diffGBias;
	logic signed [8:0] diffBBias;
	logic signed [8:0] lumaGBias;
	logic signed [9:0] lumaRBias;
	logic signed [9:0] lumaBBias;
	logic [7:0] pendingRunByte;
	logic [39:0] chunkBytes;
	logic [3:0] chunkLen;
	logic [`QOI_GROUP_BYTES*8-1:0] groupBytesNext;
	logic [3:0] groupLenNext;

	assign deltaReady = !groupValid || groupReady;
	assign consume = deltaValid && deltaReady;

	// Entries never written read as the all-zero pixel
	assign tableEntry.word = entryValid[hashIndex] ? indexTable[hashIndex].word : '0;

	assign samePixel = curPixel.word == prevPixel.word;
	assign indexHit = curPixel.word == tableEntry.word;
	assign alphaSame = curPixel.ch.a == prevPixel.ch.a;

	// Chunk field biases
	assign diffRG = diffR - diffG;
	assign diffBG = diffB - diffG;
	assign diffRBias = diffR + 9'sd2;
	assign diffGBias = diffG + 9'sd2;
	assign diffBBias = diffB + 9'sd2;
	assign lumaGBias = diffG + 9'sd32;
	assign lumaRBias = diffRG + 10'sd8;
	assign lumaBBias = diffBG + 10'sd8;

	assign diffFit = (diffR >= -9'sd2) && (diffR <= 9'sd1)
		&& (diffG >= -9'sd2) && (diffG <= 9'sd1)
		&& (diffB >= -9'sd2) && (diffB <= 9'sd1);
	assign lumaFit = (diffG >= -9'sd32) && (diffG <= 9'sd31)
		&& (diffRG >= -10'sd8) && (diffRG <= 10'sd7)
		&& (diffBG >= -10'sd8) && (diffBG <= 10'sd7);

	// Run byte stores length minus one
	assign pendingRunByte = {`QOI_TAG_RUN, 6'(runCount - 6'd1)};

	// Chunk for a pixel that breaks the run, top-aligned
	always_comb begin
		chunkBytes = '0;
		chunkLen = 4'd0;
		if (indexHit) begin
			chunkBytes = {`QOI_TAG_INDEX, hashIndex, 32'h0};
			chunkLen = 4'd1;
		end else if (alphaSame && diffFit) begin
			chunkBytes = {`QOI_TAG_DIFF, diffRBias[1:0], diffGBias[1:0], diffBBias[1:0], 32'h0};
			chunkLen = 4'd1;
		end else if (alphaSame && lumaFit) begin
			chunkBytes = {`QOI_TAG_LUMA, lumaGBias[5:0], lumaRBias[3:0], lumaBBias[3:0], 24'h0};
			chunkLen = 4'd2;
		end else if (alphaSame) begin
			chunkBytes = {`QOI_OP_RGB, curPixel.ch.r, curPixel.ch.g, curPixel.ch.b, 8'h00};
			chunkLen = 4'd4;
		end else begin
			chunkBytes = {`QOI_OP_RGBA, curPixel.word};
			chunkLen = 4'd5;
		end
	end

	// Run handling and group assembly
	always_comb begin
		runNext = runCount + 6'd1;
		runCountNext = runCount;
		groupBytesNext = '0;
		groupLenNext = 4'd0;
		tableWrite = 1'b0;
		if (samePixel) begin
			if (runNext == `QOI_RUN_MAX || isLast) begin
				groupBytesNext = {`QOI_TAG_RUN, runCount, 40'h0};
				groupLenNext = 4'd1;
				runCountNext = 6'd0;
			end else begin
				runCountNext = runNext;
			end
		end else begin
			runCountNext = 6'd0;
			tableWrite = !indexHit;
			if (runCount != 6'd0) begin
				groupBytesNext = {pendingRunByte, chunkBytes};
				groupLenNext = chunkLen + 4'd1;
			end else begin
				groupBytesNext = {chunkBytes, 8'h00};
				groupLenNext = chunkLen;
			end
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			groupValid <= 1'b0;
			runCount <= 6'd0;
			entryValid <= '0;
		end else begin
			if (consume) begin
				groupValid <= 1'b1;
				runCount <= runCountNext;
				if (tableWrite) begin
					entryValid[hashIndex] <= 1'b1;
				end
			end else if (groupReady) begin
				groupValid <= 1'b0;
			end
		end
	end

	// Group payload and table storage
	always_ff @(posedge clk) begin
		if (consume) begin
			groupBytes <= groupBytesNext;
			groupLen <= groupLenNext;
			groupLast <= isLast;
			if (tableWrite) begin
				indexTable[hashIndex] <= curPixel;
			end
		end
	end

	// A pending run plus the widest chunk fits one group
	assert property (@(posedge clk) disable iff (reset)
		groupValid |-> groupLen <= `QOI_GROUP_BYTES);

endmodule

// ==== design/qoiPkg.sv ====
// ####################
// QOI encoder package
// Pixel type shared by the pipeline stages
// ####################
`include "qoiEncoder_macros.svh"

package qoiPkg;

	// One pixel split into its channels, red in the top byte
	typedef struct packed {
		logic [`QOI_CHANNEL_WIDTH-1:0] r;
		logic [`QOI_CHANNEL_WIDTH-1:0] g;
		logic [`QOI_CHANNEL_WIDTH-1:0] b;
		logic [`QOI_CHANNEL_WIDTH-1:0] a;
	} qoiChannels_t;

	// Same pixel seen as one raw word
	// Raw view for compares and table storage, channel view for chunk fields
	typedef union packed {
		logic [4*`QOI_CHANNEL_WIDTH-1:0] word;
		qoiChannels_t ch;
	} qoiPixel_u;

endpackage

// ==== tb/qoiEncoderTb.sv ====
// ####################
// QOI encoder testbench
// Directed and random images checked against
// a reference encoder
// ####################
`timescale 1ns/1ns
`include "qoiEncoder_macros.svh"

module qoiEncoderTb;

	logic clk;
	logic reset;
	logic pixelReq;
	logic [31:0] pixelData;
	logic pixelLast;
	logic pixelAck;
	logic byteReq;
	logic [7:0] byteData;
	logic byteLast;
	logic byteAck;

	integer seed;
	logic [31:0] pixels [$];
	int imageStart [$];
	string imageName [$];
	logic [7:0] expectQ [$];
	logic [7:0] expectByte;
	logic expectLast;
	logic lastSeen;
	string testName;
	int errorCount;
	int passCount;
	longint watchdogNs;

	qoiEncoderTop UUT (
		.clk(clk),
		.reset(reset),
		.pixelReq(pixelReq),
		.pixelData(pixelData),
		.pixelLast(pixelLast),
		.pixelAck(pixelAck),
		.byteReq(byteReq),
		.byteData(byteData),
		.byteLast(byteLast),
		.byteAck(byteAck)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Inputs move 5 ns after the rising edge
	task automatic stepClock();
		@(posedge clk);
		#5;
	endtask

	function automatic int randomIn(input int low, input int high);
		return low + int'($unsigned($random(seed)) % (high - low + 1));
	endfunction

	function automatic logic [7:0] clampChannel(input int value);
		return value < 0 ? 8'd0 : (value > 255 ? 8'd255 : 8'(value));
	endfunction

	// Next pixel as a step from the one before it
	task automatic stepPixel(input int dr, input int dg, input int db, input int da);
		qoiPkg::qoiPixel_u px;
		px.word = pixels[$];
		px.ch.r = clampChannel(int'(px.ch.r) + dr);
		px.ch.g = clampChannel(int'(px.ch.g) + dg);
		px.ch.b = clampChannel(int'(px.ch.b) + db);
		px.ch.a = clampChannel(int'(px.ch.a) + da);
		pixels.push_back(px.word);
	endtask

	task automatic openImage(input string name);
		imageStart.push_back(pixels.size());
		imageName.push_back(name);
	endtask

	// Reference encoder, queues the bytes one image should produce
	task automatic encodeImage(input int first, input int count);
		logic [31:0] hashTable [`QOI_INDEX_SIZE];
		qoiPkg::qoiPixel_u px;
		qoiPkg::qoiPixel_u prev;
		int run;
		int hash;
		int dr;
		int dg;
		int db;
		prev.word = 32'h000000FF;
		run = 0;
		foreach (hashTable[i])
			hashTable[i] = '0;
		for (int i = 0; i < count; i++) begin
			px.word = pixels[first + i];
			if (px.word == prev.word) begin
				run++;
				if (run == `QOI_RUN_MAX || i == count - 1) begin
					expectQ.push_back({`QOI_TAG_RUN, 6'(run - 1)});
					run = 0;
				end
			end else begin
				if (run > 0) begin
					expectQ.push_back({`QOI_TAG_RUN, 6'(run - 1)});
					run = 0;
				end
				hash = (px.ch.r * 3 + px.ch.g * 5 + px.ch.b * 7 + px.ch.a * 11) % `QOI_INDEX_SIZE;
				dr = int'(px.ch.r) - int'(prev.ch.r);
				dg = int'(px.ch.g) - int'(prev.ch.g);
				db = int'(px.ch.b) - int'(prev.ch.b);
				if (hashTable[hash] == px.word) begin
					expectQ.push_back({`QOI_TAG_INDEX, 6'(hash)});
				end else if (px.ch.a != prev.ch.a) begin
					expectQ.push_back(`QOI_OP_RGBA);
					expectQ.push_back(px.ch.r);
					expectQ.push_back(px.ch.g);
					expectQ.push_back(px.ch.b);
					expectQ.push_back(px.ch.a);
				end else if (dr >= -2 && dr <= 1 && dg >= -2 && dg <= 1 && db >= -2 && db <= 1) begin
					expectQ.push_back({`QOI_TAG_DIFF, 2'(dr + 2), 2'(dg + 2), 2'(db + 2)});
				end else if (dg >= -32 && dg <= 31 && dr - dg >= -8 && dr - dg <= 7
					&& db - dg >= -8 && db - dg <= 7) begin
					expectQ.push_back({`QOI_TAG_LUMA, 6'(dg + 32)});
					expectQ.push_back({4'(dr - dg + 8), 4'(db - dg + 8)});
				end else begin
					expectQ.push_back(`QOI_OP_RGB);
					expectQ.push_back(px.ch.r);
					expectQ.push_back(px.ch.g);
					expectQ.push_back(px.ch.b);
				end
				hashTable[hash] = px.word;
				prev = px;
			end
		end
		repeat (`QOI_FOOTER_LEN - 1)
			expectQ.push_back(8'h00);
		expectQ.push_back(8'h01);
	endtask

	task automatic buildImages();
		int dg;
		// 62 + 8 against the start pixel
		openImage("run");
		repeat (70)
			pixels.push_back(32'h000000FF);
		openImage("index");
		pixels.push_back(32'h0A141EFF);
		pixels.push_back(32'hC86432FF);
		pixels.push_back(32'h0A141EFF);
		pixels.push_back(32'hC86432FF);
		pixels.push_back(32'h5A3C1E80);
		repeat (3)
			pixels.push_back(32'h0A141EFF);
		pixels.push_back(32'hC86432FF);
		// Small steps, then green steps near 20 and at the luma edges
		openImage("diffLuma");
		pixels.push_back(32'h646464FF);
		stepPixel(1, 1, 1, 0);
		stepPixel(-2, -2, -2, 0);
		stepPixel(0, -1, 1, 0);
		stepPixel(22, 20, 15, 0);
		stepPixel(-20, -20, -20, 0);
		stepPixel(38, 31, 23, 0);
		stepPixel(-40, -32, -40, 0);
		// Pending runs in front of wide chunks
		openImage("rgbRgba");
		repeat (2)
			pixels.push_back(32'h000000FF);
		pixels.push_back(32'hC80A5AFF);
		pixels.push_back(32'hC80A5A64);
		repeat (4)
			pixels.push_back(32'h14DC0564);
		repeat (5)
			pixels.push_back(32'h14DC05FF);
		pixels.push_back(32'h01020304);
		openImage("random");
		pixels.push_back(32'h808080FF);
		while (pixels.size() - imageStart[$] < 300) begin
			case (randomIn(0, 5))
				0: repeat (randomIn(1, 70))
					pixels.push_back(pixels[$]);
				1: stepPixel(randomIn(-2, 1), randomIn(-2, 1), randomIn(-2, 1), 0);
				2: begin
					dg = randomIn(-32, 31);
					stepPixel(dg + randomIn(-8, 7), dg, dg + randomIn(-8, 7), 0);
				end
				3: pixels.push_back(pixels[randomIn(imageStart[$], pixels.size() - 1)]);
				4: stepPixel(randomIn(-128, 127), randomIn(-128, 127), randomIn(-128, 127), 0);
				default: stepPixel(0, 0, 0, randomIn(-60, 60));
			endcase
		end
	endtask

	// Source side of the pixel handshake
	task automatic sendPixel(input logic [31:0] word, input logic last);
		pixelData = word;
		pixelLast = last;
		pixelReq = 1'b1;
		stepClock();
		while (!pixelAck)
			stepClock();
		pixelReq = 1'b0;
		stepClock();
		while (pixelAck)
			stepClock();
	endtask

	task automatic runImage(input int num);
		int first;
		int count;
		int startErrors;
		first = imageStart[num];
		count = (num + 1 < imageStart.size()) ? imageStart[num + 1] - first
			: pixels.size() - first;
		testName = imageName[num];
		startErrors = errorCount;
		expectQ.delete();
		encodeImage(first, count);
		reset = 1'b1;
		repeat (10)
			stepClock();
		reset = 1'b0;
		lastSeen = 1'b0;
		for (int i = 0; i < count; i++) begin
			sendPixel(pixels[first + i], i == count - 1);
		end
		while (!lastSeen)
			stepClock();
		assert (expectQ.size() == 0)
		else begin
			$display("Test %s: %0d expected bytes were never sent", testName, expectQ.size());
			errorCount++;
		end
		if (errorCount == startErrors) begin
			passCount++;
		end
		$display("Test %s finished: %0d pixels, %0d errors", testName, count,
			errorCount - startErrors);
	endtask

	// Sink with a random wait of 0 to 3 cycles before each ack
	initial begin
		logic gotLast;
		byteAck = 1'b0;
		lastSeen = 1'b0;
		forever begin
			stepClock();
			if (byteReq) begin
				assert (expectQ.size() > 0) begin
					expectByte = expectQ.pop_front();
				end else begin
					$display("Test %s: the DUT sent more bytes than expected", testName);
					errorCount++;
				end
				expectLast = expectQ.size() == 0;
				gotLast = byteLast;
				repeat (randomIn(0, 3))
					stepClock();
				byteAck = 1'b1;
				stepClock();
				while (byteReq)
					stepClock();
				byteAck = 1'b0;
				if (gotLast) begin
					lastSeen = 1'b1;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		$rose(byteAck) |-> byteData == expectByte)
	else begin
		$display("Fail %s: expected byte %02h, actual %02h", testName,
			$sampled(expectByte), $sampled(byteData));
		errorCount++;
	end

	// End marker flag only on the final byte
	assert property (@(posedge clk) disable iff (reset)
		$rose(byteAck) |-> byteLast == expectLast)
	else begin
		$display("Fail %s: expected byteLast %0b, actual %0b", testName,
			$sampled(expectLast), $sampled(byteLast));
		errorCount++;
	end

	assert property (@(posedge clk) disable iff (reset)
		$rose(byteReq) |-> !$past(byteAck))
	else begin
		$display("Test %s: byteReq rose before the sink had dropped byteAck", testName);
		errorCount++;
	end

	assert property (@(posedge clk) disable iff (reset)
		$fell(pixelAck) |-> !$past(pixelReq))
	else begin
		$display("Test %s: pixelAck dropped while pixelReq was still high", testName);
		errorCount++;
	end

	initial begin
		reset = 1'b1;
		pixelReq = 1'b0;
		pixelData = '0;
		pixelLast = 1'b0;
		seed = 32'h6a3ae1b7;
		errorCount = 0;
		passCount = 0;
		buildImages();
		// Six bytes per pixel at most, six cycles per byte
		watchdogNs = (longint'(pixels.size()) * 6 + imageStart.size() * 8) * 6 * 40;
		stepClock();
		foreach (imageStart[i])
			runImage(i);
		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d", imageStart.size(),
			passCount, imageStart.size() - passCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#1;
		#(watchdogNs);
		$display("Watchdog expired: the DUT stopped answering a handshake in test %s", testName);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+design
design/qoiPkg.sv
design/qoiDeltaStage.sv
design/qoiOpSelect.sv
design/qoiByteEmitter.sv
design/qoiEncoderTop.sv
tb/qoiEncoderTb.sv
